// File: src.f
+incdir+hw
hw/i2c_bus_pkg.sv
hw/mem_cmd_pkg.sv
hw/cmd_fifo.sv
hw/mem_port_sequencer.sv
hw/i2c_bus_receiver.sv
hw/i2c_mem_bridge.sv
dv/i2c_mem_bridge_properties.sv
dv/i2c_mem_bridge_tb.sv

// File: Makefile
# Verilator build and run of the I2C memory bridge testbench

VERILATOR ?= verilator
TOP       ?= i2c_mem_bridge_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/i2c_mem_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_consts.svh"

module i2c_mem_bridge_tb;

	localparam int HALF      = 40; // SCL half-period in clk cycles
	localparam int MEM_SIZE  = 1 << `MEM_AW;
	localparam int N_RANDOM  = 40;
	localparam int MAX_BURST = 6;
	// Longest transfer is a pointer set plus a 6 byte read, about 12 frames of 9 bits
	localparam int CYC_PER_XFER = (12 * 9 + 8) * 2 * HALF;
	// Directed ones, random ones, and one read-back per touched address
	localparam int N_XFER  = 6 + N_RANDOM + (N_RANDOM + 3) * MAX_BURST;
	localparam int TIMEOUT = N_XFER * CYC_PER_XFER * 3 / 2;

	logic               clk;
	logic               arst_n;
	logic [2:0]         addr_bits;
	logic               scl;
	logic               sda_drv; // Controller side of the open drain
	wire                sda_in;
	logic [`MEM_DW-1:0] rdata;
	logic               xfc_read;
	wire                sda_out;
	wire                op;
	wire                xfc_write;
	wire  [`MEM_AW-1:0] wraddr;
	wire  [`MEM_DW-1:0] wdata;

	logic [`MEM_DW-1:0] mem_model [MEM_SIZE]; // Answers the DUT
	logic [`MEM_DW-1:0] exp_mem [MEM_SIZE];   // Stimulus only
	bit                 touched [MEM_SIZE];
	int                 touched_q[$];
	logic [18:0]        exp_wr_q[$];          // {addr, data} in bus order
	logic [31:0]        rng_state;
	logic [`MEM_AW-1:0] pend_addr;
	int                 pend_cnt;
	int                 strobe_count;
	int                 cycles;

	assign sda_in = sda_drv & sda_out; // Wired AND

	i2c_mem_bridge i_dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.addr_bits (addr_bits),
		.sda_in    (sda_in),
		.scl       (scl),
		.rdata     (rdata),
		.xfc_read  (xfc_read),
		.sda_out   (sda_out),
		.op        (op),
		.xfc_write (xfc_write),
		.wraddr    (wraddr),
		.wdata     (wdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] rand32();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'((rand32() >> 8) % 32'(hi - lo + 1)); // High bits, better period
	endfunction

	// Initial memory contents, every address bit matters
	function automatic logic [7:0] fill_byte(input logic [10:0] a);
		return a[7:0] ^ {a[10:8], 5'h15};
	endfunction

	function automatic logic [7:0] dev_byte(input logic [2:0] bits, input logic rw);
		return {`DEV_ADDR_HI, bits, rw};
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1; // Inputs change after the edge
		end
	endtask

	task automatic stop_failed();
		$display("Test failed");
		$fatal(1, "Stopping at first failure");
	endtask

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
			stop_failed();
		end
	endtask

	task automatic note_touched(input logic [10:0] a);
		if (!touched[a]) begin
			touched[a] = 1'b1;
			touched_q.push_back(int'(a));
		end
	endtask

	//////////////////////////////
	// I2C controller
	//////////////////////////////

	task automatic bus_start();
		sda_drv = 1'b1; // Bus idle, SCL high
		scl     = 1'b1;
		wait_cycles(HALF);
		sda_drv = 1'b0; // SDA falls with SCL high
		wait_cycles(HALF);
		scl = 1'b0;
	endtask

	task automatic bus_stop();
		wait_cycles(HALF / 2);
		sda_drv = 1'b0;
		wait_cycles(HALF / 2);
		scl = 1'b1;
		wait_cycles(HALF);
		sda_drv = 1'b1; // SDA rises with SCL high
		wait_cycles(HALF);
	endtask

	// One SCL period, SDA set mid low, sampled mid high
	task automatic send_bit(input logic b, output logic s);
		wait_cycles(HALF / 2);
		sda_drv = b;
		wait_cycles(HALF / 2);
		scl = 1'b1;
		wait_cycles(HALF / 2);
		s = sda_in;
		wait_cycles(HALF / 2);
		scl = 1'b0;
	endtask

	task automatic write_byte(input logic [7:0] b, output logic acked);
		logic s;
		for (int i = 7; i >= 0; i--)
			send_bit(b[i], s);
		send_bit(1'b1, s); // Release for the target ACK
		acked = !s;
	endtask

	task automatic read_byte(output logic [7:0] b, input logic ack);
		logic s;
		for (int i = 7; i >= 0; i--) begin
			send_bit(1'b1, s);
			b[i] = s;
		end
		send_bit(!ack, s); // Low is ACK, high ends the read
	endtask

	//////////////////////////////
	// Transfers
	//////////////////////////////

	// Start, device address and two address bytes, no stop
	task automatic set_pointer(input logic [10:0] a);
		logic ack;
		bus_start();
		write_byte(dev_byte(addr_bits, 1'b0), ack);
		check_eq("ACK for device address", ack, 1);
		write_byte({5'b0, a[10:8]}, ack);
		check_eq("ACK for address high byte", ack, 1);
		write_byte(a[7:0], ack);
		check_eq("ACK for address low byte", ack, 1);
	endtask

	task automatic write_burst(input logic [10:0] a, input int n);
		logic       ack;
		logic [7:0] d;
		logic [10:0] p;
		int         waited;
		set_pointer(a);
		p = a;
		for (int i = 0; i < n; i++) begin
			d = 8'(rand32() >> 16);
			exp_wr_q.push_back({p, d}); // Queued before the DUT can strobe
			exp_mem[p] = d;
			note_touched(p);
			write_byte(d, ack);
			check_eq("ACK for data byte", ack, 1);
			p = p + 11'd1; // Wraps 2047 to 0
		end
		bus_stop();
		waited = 0;
		while (exp_wr_q.size() != 0 && waited < 50) begin
			wait_cycles(1);
			waited++;
		end
		check_eq("writes still pending after stop", exp_wr_q.size(), 0);
	endtask

	task automatic read_burst(input logic [10:0] a, input int n);
		logic        ack;
		logic [7:0]  b;
		logic [10:0] p;
		set_pointer(a);
		bus_stop();
		bus_start();
		write_byte(dev_byte(addr_bits, 1'b1), ack);
		check_eq("ACK for read device address", ack, 1);
		p = a;
		for (int i = 0; i < n; i++) begin
			read_byte(b, i != n - 1); // NACK on the last one
			check_eq($sformatf("read data at 0x%0h", p), b, exp_mem[p]);
			p = p + 11'd1;
		end
		bus_stop();
	endtask

	// Address with other pin bits, must be ignored
	task automatic foreign_transfer();
		logic       ack;
		logic [2:0] other;
		int         base;
		other = addr_bits ^ 3'(rand_range(1, 7));
		base  = strobe_count;
		bus_start();
		write_byte(dev_byte(other, 1'b0), ack);
		check_eq("ACK for foreign device address", ack, 0);
		repeat (2) begin
			write_byte(8'(rand32() >> 16), ack);
			check_eq("ACK for byte to foreign device", ack, 0);
		end
		check_eq("memory strobes in foreign transfer", strobe_count, base);
		bus_stop();
	endtask

	//////////////////////////////
	// Memory model
	//////////////////////////////

	always @(posedge clk) begin
		logic [18:0] e;
		if (xfc_write) begin
			strobe_count++;
			if (exp_wr_q.size() == 0) begin
				$display("Memory write to 0x%0h that no bus transfer asked for", wraddr);
				stop_failed();
			end
			e = exp_wr_q.pop_front();
			check_eq("write address", wraddr, e[18:8]);
			check_eq("write data", wdata, e[7:0]);
			mem_model[wraddr] = wdata;
		end
		if (op) begin
			strobe_count++;
			pend_addr = wraddr;
			pend_cnt  = rand_range(1, 5); // Read latency
		end
		#1;
		xfc_read = 1'b0;
		if (pend_cnt > 0) begin
			pend_cnt--;
			if (pend_cnt == 0) begin
				xfc_read = 1'b1;
				rdata    = mem_model[pend_addr];
			end
		end
	end

	// Run limit and bound assertion watch
	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("Timeout, run still busy after %0d clock cycles", TIMEOUT);
			stop_failed();
		end
		if (i_dut.u_props.any_fail === 1'b1) begin
			$display("A bound assertion on the DUT failed");
			stop_failed();
		end
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		int          kind;
		int          len;
		logic [10:0] a;
		arst_n       = 1'b0;
		addr_bits    = 3'b101;
		scl          = 1'b1;
		sda_drv      = 1'b1;
		rdata        = '0;
		xfc_read     = 1'b0;
		rng_state    = 32'hf7af4303;
		pend_cnt     = 0;
		strobe_count = 0;
		cycles       = 0;
		for (int i = 0; i < MEM_SIZE; i++) begin
			mem_model[i] = fill_byte(11'(i));
			exp_mem[i]   = fill_byte(11'(i));
			touched[i]   = 1'b0;
		end
		wait_cycles(10);
		arst_n = 1'b1;
		wait_cycles(2);

		// Quiet outputs before any bus activity
		check_eq("xfc_write after reset", xfc_write, 0);
		check_eq("op after reset", op, 0);
		check_eq("sda_out after reset", sda_out, 1);

		// Write burst then read it back
		a   = 11'(rand_range(0, MEM_SIZE - 1));
		len = rand_range(1, MAX_BURST);
		write_burst(a, len);
		read_burst(a, len);

		// Wrap from the top address
		write_burst(11'd2047, 4);
		read_burst(11'd2046, 5);

		foreign_transfer();

		for (int k = 0; k < N_RANDOM; k++) begin
			if (rand_range(0, 3) == 0)
				addr_bits = 3'(rand_range(0, 7)); // Device moves
			kind = rand_range(0, 7);
			len  = rand_range(1, MAX_BURST);
			if (kind < 4) begin
				write_burst(11'(rand_range(0, MEM_SIZE - 1)), len);
			end else if (kind < 7) begin
				if (touched_q.size() > 0)
					a = 11'(touched_q[rand_range(0, touched_q.size() - 1)]);
				else
					a = 11'(rand_range(0, MEM_SIZE - 1));
				read_burst(a, len);
			end else begin
				foreign_transfer();
			end
		end

		// Full read-back of everything written
		foreach (touched_q[i])
			read_burst(11'(touched_q[i]), 1);

		wait_cycles(4);
		if (i_dut.u_props.any_fail !== 1'b1) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/i2c_mem_bridge_properties.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_mem_bridge_properties
	import i2c_bus_pkg::*;
(
	input wire             clk,
	input wire             arst_n,
	input wire             xfc_write,
	input wire             op,
	input wire             cmd_push,
	input wire             cmd_full,
	input wire             rd_push,
	input wire             rd_full,
	input wire             rd_req,    // Read byte slot opens
	input wire             rd_empty,
	input wire bus_phase_t phase
);

	// Sticky flags, one per property
	logic bad_excl    = 1'b0;
	logic bad_wr_len  = 1'b0;
	logic bad_op_len  = 1'b0;
	logic bad_push    = 1'b0;
	logic bad_rd_push = 1'b0;
	logic bad_pop     = 1'b0;
	logic bad_idle    = 1'b0;
	wire  any_fail;

	assign any_fail = bad_excl | bad_wr_len | bad_op_len | bad_push
	                | bad_rd_push | bad_pop | bad_idle;

	//////////////////////////////
	// Memory strobes
	//////////////////////////////

	a_strobe_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(xfc_write && op))
		else begin
			bad_excl = 1'b1;
			$error("xfc_write and op high together");
		end

	a_write_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		xfc_write |=> !xfc_write)
		else begin
			bad_wr_len = 1'b1;
			$error("xfc_write longer than one cycle");
		end

	a_op_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		op |=> !op)
		else begin
			bad_op_len = 1'b1;
			$error("op longer than one cycle");
		end

	//////////////////////////////
	// FIFO levels and bus state
	//////////////////////////////

	// Command FIFO sized so that it never fills at the legal SCL rate
	a_no_full_push: assert property (@(posedge clk) disable iff (!arst_n)
		!(cmd_push && cmd_full))
		else begin
			bad_push = 1'b1;
			$error("push into full command FIFO");
		end

	// One prefetch in flight at most
	a_no_rd_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		!(rd_push && rd_full))
		else begin
			bad_rd_push = 1'b1;
			$error("push into full read FIFO");
		end

	a_no_underrun: assert property (@(posedge clk) disable iff (!arst_n)
		rd_req |-> !rd_empty)
		else begin
			bad_pop = 1'b1;
			$error("read byte slot with empty read FIFO");
		end

	// Prefetch ends at the NACK, so a stopped bus leaves no byte behind
	a_idle_after_stop: assert property (@(posedge clk) disable iff (!arst_n)
		(phase == PH_IDLE) |-> rd_empty)
		else begin
			bad_idle = 1'b1;
			$error("read byte left in read FIFO while bus is idle");
		end

endmodule

bind i2c_mem_bridge i2c_mem_bridge_properties u_props (
	.clk       (clk),
	.arst_n    (arst_n),
	.xfc_write (xfc_write),
	.op        (op),
	.cmd_push  (cmd_push),
	.cmd_full  (cmd_full),
	.rd_push   (rd_push),
	.rd_full   (rd_full),
	.rd_req    (u_receiver.load_tx),
	.rd_empty  (rd_empty),
	.phase     (u_receiver.phase)
);

`default_nettype wire

// File: hw/i2c_mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_consts.svh"

module i2c_mem_bridge
	import mem_cmd_pkg::*;
(
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire  [2:0]           addr_bits,
	input  wire                  sda_in,
	input  wire                  scl,
	input  wire  [`MEM_DW-1:0]   rdata,
	input  wire                  xfc_read,
	output wire                  sda_out,
	output wire                  op,
	output wire                  xfc_write,
	output wire  [`MEM_AW-1:0]   wraddr,
	output wire  [`MEM_DW-1:0]   wdata
);

	// Receiver to sequencer commands
	wire                                   cmd_push;
	wire mem_cmd_t                         cmd_data;
	wire                                   cmd_pop;
	wire mem_cmd_t                         cmd_head;
	wire                                   cmd_empty;
	wire                                   cmd_full;

	// Sequencer to receiver read bytes
	wire                                   rd_push;
	wire [`MEM_DW-1:0]                     rd_byte;
	wire                                   rd_pop;
	wire [`MEM_DW-1:0]                     rd_head;
	wire                                   rd_empty;
	wire                                   rd_full;

	i2c_bus_receiver u_receiver (
		.clk       (clk),
		.arst_n    (arst_n),
		.scl       (scl),
		.sda_in    (sda_in),
		.addr_bits (addr_bits),
		.sda_out   (sda_out),
		.cmd_push  (cmd_push),
		.cmd_data  (cmd_data),
		.rd_empty  (rd_empty),
		.rd_head   (rd_head),
		.rd_pop    (rd_pop)
	);

	cmd_fifo #(
		.payload_t (mem_cmd_t),
		.DEPTH     (`CMD_FIFO_DEPTH)
	) u_cmd_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (cmd_push),
		.push_data (cmd_data),
		.pop       (cmd_pop),
		.head      (cmd_head),
		.empty     (cmd_empty),
		.full      (cmd_full),
		.level     ()
	);

	mem_port_sequencer u_sequencer (
		.clk       (clk),
		.arst_n    (arst_n),
		.cmd_empty (cmd_empty),
		.cmd_head  (cmd_head),
		.cmd_pop   (cmd_pop),
		.xfc_write (xfc_write),
		.op        (op),
		.wraddr    (wraddr),
		.wdata     (wdata),
		.xfc_read  (xfc_read),
		.rdata     (rdata),
		.rd_push   (rd_push),
		.rd_data   (rd_byte)
	);

	// Same FIFO, byte payload
	cmd_fifo #(
		.payload_t (logic [`MEM_DW-1:0]),
		.DEPTH     (`RD_FIFO_DEPTH)
	) u_rd_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (rd_push),
		.push_data (rd_byte),
		.pop       (rd_pop),
		.head      (rd_head),
		.empty     (rd_empty),
		.full      (rd_full),
		.level     ()
	);

endmodule

`default_nettype wire

// File: hw/i2c_bus_receiver.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_consts.svh"

module i2c_bus_receiver
	import i2c_bus_pkg::*, mem_cmd_pkg::*;
(
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire                  scl,
	input  wire                  sda_in,
	input  wire  [2:0]           addr_bits, // Low bits of device address
	output logic                 sda_out,   // 1 releases the line
	// Command FIFO side
	output logic                 cmd_push,
	output mem_cmd_t             cmd_data,
	// Read FIFO side
	input  wire                  rd_empty,
	input  wire  [`MEM_DW-1:0]   rd_head,
	output logic                 rd_pop
);

	logic [`SYNC_STAGES-1:0] scl_sync;
	logic [`SYNC_STAGES-1:0] sda_sync;
	logic                    scl_s;
	logic                    sda_s;
	logic                    scl_d;
	logic                    sda_d;
	logic                    scl_rise;
	logic                    scl_fall;
	logic                    start_det;
	logic                    stop_det;

	bus_phase_t              phase;
	logic [3:0]              bit_cnt;  // SCL rises seen in this frame
	logic [7:0]              rx_byte;
	logic [`MEM_DW-1:0]      tx_byte;  // Remaining read bits, MSB next
	logic [`MEM_AW-1:0]      addr_ptr;
	logic                    mack;     // Controller ACKed our byte
	logic                    dev_match;
	logic                    push_wr;
	logic                    push_rd;
	logic                    load_tx;
	logic [`MEM_DW-1:0]      tx_src;

	//////////////////////////////
	// SCL and SDA sync
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scl_sync <= '1; // Idle bus is high
			sda_sync <= '1;
			scl_d    <= 1'b1;
			sda_d    <= 1'b1;
		end else begin
			scl_sync <= {scl_sync[`SYNC_STAGES-2:0], scl};
			sda_sync <= {sda_sync[`SYNC_STAGES-2:0], sda_in};
			scl_d    <= scl_s;
			sda_d    <= sda_s;
		end
	end

	assign scl_s = scl_sync[`SYNC_STAGES-1];
	assign sda_s = sda_sync[`SYNC_STAGES-1];

	assign scl_rise  = scl_s && !scl_d;
	assign scl_fall  = !scl_s && scl_d;
	// SDA edge while SCL stays high
	assign start_det = scl_s && scl_d && sda_d && !sda_s;
	assign stop_det  = scl_s && scl_d && !sda_d && sda_s;

	//////////////////////////////
	// Frame decodes
	//////////////////////////////

	assign dev_match = (rx_byte[7:1] == {`DEV_ADDR_HI, addr_bits});

	// Write command at the end of the data byte ACK slot
	assign push_wr = scl_fall && (bit_cnt == 4'(FRAME_BITS)) && (phase == PH_WR_DATA);

	// Read prefetch: on our address ACK, then on each controller ACK
	assign push_rd = (scl_fall && (bit_cnt == 4'd8) && (phase == PH_DEV_ADDR)
	                  && dev_match && rx_byte[0])
	              || (scl_rise && (bit_cnt == 4'd8) && (phase == PH_RD_DATA) && !sda_s);

	// Start of a read byte slot
	assign load_tx = scl_fall && (bit_cnt == 4'(FRAME_BITS))
	              && (((phase == PH_DEV_ADDR) && rx_byte[0]) || ((phase == PH_RD_DATA) && mack));

	assign rd_pop = load_tx && !rd_empty;
	assign tx_src = rd_empty ? '1 : rd_head; // All ones on underrun

	//////////////////////////////
	// Bus FSM
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase    <= PH_IDLE;
			bit_cnt  <= '0;
			rx_byte  <= '0;
			tx_byte  <= '1;
			addr_ptr <= '0;
			mack     <= 1'b0;
			sda_out  <= 1'b1;
			cmd_push <= 1'b0;
		end else begin
			cmd_push <= push_wr || push_rd;
			if (start_det) begin // Also repeated start
				phase   <= PH_DEV_ADDR;
				bit_cnt <= '0;
				sda_out <= 1'b1;
			end else if (stop_det) begin
				phase   <= PH_IDLE;
				sda_out <= 1'b1;
			end else if (phase != PH_IDLE && phase != PH_IGNORE) begin
				if (scl_rise) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt < 4'd8)
						rx_byte <= {rx_byte[6:0], sda_s}; // MSB first
					else if (phase == PH_RD_DATA)
						mack <= !sda_s;
					if (push_rd)
						addr_ptr <= addr_ptr + 1'b1; // Wraps 2047 to 0
				end else if (scl_fall) begin
					case (bit_cnt)
						4'd8: begin // ACK slot opens
							if (phase == PH_RD_DATA) begin
								sda_out <= 1'b1; // Controller answers
							end else if (phase == PH_DEV_ADDR && !dev_match) begin
								phase   <= PH_IGNORE;
								sda_out <= 1'b1;
							end else begin
								sda_out <= 1'b0;
								if (push_rd)
									addr_ptr <= addr_ptr + 1'b1;
							end
						end
						4'(FRAME_BITS): begin // ACK slot closes
							bit_cnt <= '0;
							sda_out <= 1'b1;
							case (phase)
								PH_DEV_ADDR: phase <= rx_byte[0] ? PH_RD_DATA : PH_ADDR_HI;
								PH_ADDR_HI: begin
									addr_ptr[`MEM_AW-1:8] <= rx_byte[`MEM_AW-9:0];
									phase <= PH_ADDR_LO;
								end
								PH_ADDR_LO: begin
									addr_ptr[7:0] <= rx_byte;
									phase <= PH_WR_DATA;
								end
								PH_WR_DATA: addr_ptr <= addr_ptr + 1'b1;
								PH_RD_DATA: begin
									if (!mack)
										phase <= PH_IGNORE; // NACK ends the read
								end
								default: phase <= PH_IGNORE;
							endcase
							if (load_tx) begin
								sda_out <= tx_src[`MEM_DW-1];
								tx_byte <= {tx_src[`MEM_DW-2:0], 1'b1};
							end
						end
						default: begin
							if (phase == PH_RD_DATA) begin // Bits 6 to 0
								sda_out <= tx_byte[`MEM_DW-1];
								tx_byte <= {tx_byte[`MEM_DW-2:0], 1'b1};
							end
						end
					endcase
				end
			end
		end
	end

	// Command record, loaded with the push
	always_ff @(posedge clk) begin
		if (push_wr || push_rd) begin
			cmd_data.kind <= push_rd ? CMD_READ : CMD_WRITE;
			cmd_data.addr <= addr_ptr;
			cmd_data.data <= rx_byte;
		end
	end

endmodule

`default_nettype wire

// File: hw/mem_port_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_consts.svh"

module mem_port_sequencer
	import mem_cmd_pkg::*;
(
	input  wire                      clk,
	input  wire                      arst_n,
	// Command FIFO side
	input  wire                      cmd_empty,
	input  wire mem_cmd_t            cmd_head,
	output logic                     cmd_pop,
	// Memory strobe port
	output logic                     xfc_write,
	output logic                     op,       // Read request
	output logic [`MEM_AW-1:0]       wraddr,
	output logic [`MEM_DW-1:0]       wdata,
	input  wire                      xfc_read, // Read done
	input  wire  [`MEM_DW-1:0]       rdata,
	// Read FIFO side
	output logic                     rd_push,
	output logic [`MEM_DW-1:0]       rd_data
);

	typedef enum logic [1:0] {
		S_IDLE    = 2'd0,
		S_ISSUE   = 2'd1, // Strobe is high this cycle
		S_WAIT_RD = 2'd2  // Memory latency is open ended
	} seq_state_t;

	seq_state_t state;
	cmd_kind_t  kind; // Command in flight

	// Take a command only when nothing is outstanding
	assign cmd_pop = (state == S_IDLE) && !cmd_empty;

	//////////////////////////////
	// Control
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= S_IDLE;
			kind      <= CMD_WRITE;
			xfc_write <= 1'b0;
			op        <= 1'b0;
			rd_push   <= 1'b0;
		end else begin
			xfc_write <= 1'b0; // All strobes one cycle
			op        <= 1'b0;
			rd_push   <= 1'b0;
			case (state)
				S_IDLE: begin
					if (cmd_pop) begin
						kind      <= cmd_head.kind;
						xfc_write <= (cmd_head.kind == CMD_WRITE);
						op        <= (cmd_head.kind == CMD_READ);
						state     <= S_ISSUE;
					end
				end
				S_ISSUE: begin
					// Writes are fire and forget
					state <= (kind == CMD_READ) ? S_WAIT_RD : S_IDLE;
				end
				S_WAIT_RD: begin
					if (xfc_read) begin
						rd_push <= 1'b1; // Byte lands in read FIFO
						state   <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Address and data
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (cmd_pop) begin
			wraddr <= cmd_head.addr; // Shared by write and read
			wdata  <= cmd_head.data;
		end
		if (state == S_WAIT_RD && xfc_read)
			rd_data <= rdata; // Captured with read done
	end

endmodule

`default_nettype wire

// File: hw/cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire                          push,
	input  wire payload_t                push_data,
	input  wire                          pop,
	output payload_t                     head,
	output logic                         empty,
	output logic                         full,
	output logic [$clog2(DEPTH+1)-1:0]   level
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t      mem [DEPTH]; // Storage, no reset needed
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic          do_push;
	logic          do_pop;

	// Pointer step with wrap, DEPTH need not be a power of two
	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
		if (p == PW'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign do_push = push && !full; // Push into full FIFO dropped
	assign do_pop  = pop && !empty; // Pop of empty FIFO dropped
	assign empty   = (level == '0);
	assign full    = (level == DEPTH);
	assign head    = mem[rd_ptr]; // Oldest entry

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level; // Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/mem_cmd_pkg.sv
`default_nettype none

`include "i2c_consts.svh"

package mem_cmd_pkg;

	//////////////////////////////
	// Command record
	//////////////////////////////

	typedef enum logic {
		CMD_WRITE = 1'b0,
		CMD_READ  = 1'b1
	} cmd_kind_t;

	// One memory access as queued in the command FIFO
	// kind + address + data = 20 bits
	typedef struct packed {
		cmd_kind_t          kind;
		logic [`MEM_AW-1:0] addr;
		logic [`MEM_DW-1:0] data; // Don't care for reads
	} mem_cmd_t;

endpackage

`default_nettype wire

// File: hw/i2c_bus_pkg.sv
`default_nettype none

package i2c_bus_pkg;

	// Position of the receiver within one I2C transfer
	typedef enum logic [2:0] {
		PH_IDLE     = 3'd0, // Between stop and the next start
		PH_DEV_ADDR = 3'd1, // Device address plus R/W bit
		PH_ADDR_HI  = 3'd2, // Low three bits are memory address 10:8
		PH_ADDR_LO  = 3'd3, // Memory address 7:0
		PH_WR_DATA  = 3'd4, // Data bytes into memory
		PH_RD_DATA  = 3'd5, // Data bytes out to the controller
		PH_IGNORE   = 3'd6  // Not addressed, or read closed by NACK
	} bus_phase_t;

	// Bits per frame including the ACK slot
	localparam int unsigned FRAME_BITS = 9;

endpackage

`default_nettype wire

// File: hw/i2c_consts.svh
`ifndef I2C_CONSTS_SVH
`define I2C_CONSTS_SVH

//////////////////////////////
// Memory geometry
//////////////////////////////

`define MEM_AW 11 // 2048 entries
`define MEM_DW 8

// Fixed upper nibble of the 7-bit device address, pins give the rest
`define DEV_ADDR_HI 4'b1010

//////////////////////////////
// Buffering and sync
//////////////////////////////

`define CMD_FIFO_DEPTH 4
`define RD_FIFO_DEPTH 2 // One prefetched byte in flight at most
`define SYNC_STAGES 2 // Flops on SCL and SDA before any edge logic

`endif
